/* Bender.yml */
package:
  name: bit_unpacker

sources:
  # design, package first
  - source/unpack_pkg.sv
  - source/unpack_ctrl.sv
  - source/bit_level_cnt.sv
  - source/bit_shift_reg.sv
  - source/bit_unpacker.sv

  # testbench with bound properties
  - target: test
    files:
      - verif/unpack_props.sv
      - verif/unpack_tb.sv

/* source/bit_level_cnt.sv */
`timescale 1ns/10ps

module bit_level_cnt #(
   parameter int unsigned IN_W = 16
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  unpack_pkg::shift_cmd_t         cmd_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] width_i,
   output logic [unpack_pkg::LEVEL_W-1:0] level_o
);

   localparam logic [unpack_pkg::LEVEL_W-1:0] IN_LEVEL = IN_W[unpack_pkg::LEVEL_W-1:0];

   logic [unpack_pkg::LEVEL_W-1:0] level_q;
   logic [unpack_pkg::LEVEL_W-1:0] level_d;
   logic [unpack_pkg::LEVEL_W-1:0] add_amt;
   logic [unpack_pkg::LEVEL_W-1:0] sub_amt;

   always_comb begin
      add_amt = cmd_i.load ? IN_LEVEL : '0;
      sub_amt = cmd_i.take ? width_i : '0;
      if (cmd_i.take && cmd_i.pad) begin
         // padded field empties the queue whatever its width
         level_d = '0;
      end else begin
         level_d = level_q + add_amt - sub_amt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_d;
      end
   end

   assign level_o = level_q;

endmodule

/* source/bit_shift_reg.sv */
`timescale 1ns/10ps

module bit_shift_reg #(
   parameter int unsigned IN_W    = 16,
   parameter int unsigned FIELD_W = 12
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  unpack_pkg::shift_cmd_t         cmd_i,
   input  logic [IN_W-1:0]                in_data_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] width_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] level_i,
   output logic [FIELD_W-1:0]             field_o
);

   // queue depth, one word left over plus one new word
   localparam int unsigned QW = 2 * IN_W;

   // valid bits sit in queue_q[level-1:0], oldest bit on top
   logic [QW-1:0] queue_q;
   logic [QW-1:0] queue_d;
   logic [QW-1:0] keep_mask;
   logic [QW-1:0] kept;
   logic [QW-1:0] data_ext;
   logic [QW-1:0] head_al;

   logic [unpack_pkg::LEVEL_W-1:0] keep_cnt;
   logic [unpack_pkg::LEVEL_W-1:0] drop_sh;
   logic [unpack_pkg::LEVEL_W-1:0] pad_sh;

   logic [FIELD_W-1:0] field_mask;

   assign data_ext = {{IN_W{1'b0}}, in_data_i};

   // queue update
   always_comb begin
      if (cmd_i.take && cmd_i.pad) begin
         keep_cnt = '0;
      end else if (cmd_i.take) begin
         keep_cnt = level_i - width_i;
      end else begin
         keep_cnt = level_i;
      end

      // taken head bits are cleared so the queue stays zero above level
      keep_mask = ~({QW{1'b1}} << keep_cnt);
      kept      = queue_q & keep_mask;

      // new word lands right behind the bits that remain
      if (cmd_i.load) begin
         queue_d = (kept << IN_W) | data_ext;
      end else begin
         queue_d = kept;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         queue_q <= '0;
      end else begin
         queue_q <= queue_d;
      end
   end

   // field extraction
   always_comb begin
      drop_sh = level_i - width_i;
      pad_sh  = width_i - level_i;

      if (cmd_i.pad) begin
         // short remainder moves up, zeros fill the low end
         head_al = queue_q << pad_sh;
      end else begin
         // head width_i bits down to bit 0
         head_al = queue_q >> drop_sh;
      end

      field_mask = ~({FIELD_W{1'b1}} << width_i);
      field_o    = head_al[FIELD_W-1:0] & field_mask;
   end

endmodule

/* source/bit_unpacker.sv */
`timescale 1ns/10ps

module bit_unpacker #(
   parameter int unsigned IN_W    = 16,
   parameter int unsigned FIELD_W = 12
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           in_valid_i,
   input  logic [IN_W-1:0]                in_data_i,
   output logic                           in_ready_o,
   input  logic                           flush_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] width_i,
   output logic                           field_valid_o,
   output logic [FIELD_W-1:0]             field_o,
   output logic                           last_o,
   input  logic                           field_ready_i
);

   logic [unpack_pkg::LEVEL_W-1:0] level;
   unpack_pkg::shift_cmd_t         cmd;

   // handshakes and flush sequencing
   unpack_ctrl #(
      .IN_W(IN_W)
   ) u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .flush_i      (flush_i),
      .field_ready_i(field_ready_i),
      .width_i      (width_i),
      .level_i      (level),
      .in_ready_o   (in_ready_o),
      .field_valid_o(field_valid_o),
      .last_o       (last_o),
      .cmd_o        (cmd)
   );

   // number of bits held
   bit_level_cnt #(
      .IN_W(IN_W)
   ) u_level (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .cmd_i  (cmd),
      .width_i(width_i),
      .level_o(level)
   );

   bit_shift_reg #(
      .IN_W   (IN_W),
      .FIELD_W(FIELD_W)
   ) u_shift (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .cmd_i    (cmd),
      .in_data_i(in_data_i),
      .width_i  (width_i),
      .level_i  (level),
      .field_o  (field_o)
   );

endmodule

/* source/unpack_ctrl.sv */
`timescale 1ns/10ps

module unpack_ctrl #(
   parameter int unsigned IN_W = 16
) (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           in_valid_i,
   input  logic                           flush_i,
   input  logic                           field_ready_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] width_i,
   input  logic [unpack_pkg::LEVEL_W-1:0] level_i,
   output logic                           in_ready_o,
   output logic                           field_valid_o,
   output logic                           last_o,
   output unpack_pkg::shift_cmd_t         cmd_o
);

   // word width in the level domain
   localparam logic [unpack_pkg::LEVEL_W-1:0] IN_LEVEL = IN_W[unpack_pkg::LEVEL_W-1:0];

   unpack_pkg::ctrl_state_e state_q;
   unpack_pkg::ctrl_state_e state_d;

   logic full_field;
   logic has_bits;
   logic in_last;

   assign full_field = (level_i >= width_i);
   assign has_bits   = (level_i != '0);
   assign in_last    = (state_q == unpack_pkg::ST_LAST);

   // room for one more word only while streaming
   assign in_ready_o = (state_q == unpack_pkg::ST_STREAM) && (level_i <= IN_LEVEL);

   // a full field, or the short remainder once flushing ends
   assign field_valid_o = full_field || (in_last && has_bits);
   assign last_o        = in_last && has_bits;

   assign cmd_o.load = in_valid_i && in_ready_o;
   assign cmd_o.take = field_valid_o && field_ready_i;
   assign cmd_o.pad  = in_last;

   always_comb begin
      state_d = state_q;
      case (state_q)
         unpack_pkg::ST_STREAM: begin
            if (flush_i) begin
               state_d = unpack_pkg::ST_FLUSH;
            end
         end
         unpack_pkg::ST_FLUSH: begin
            // full fields keep draining through the normal path
            if (!has_bits) begin
               state_d = unpack_pkg::ST_STREAM;
            end else if (!full_field) begin
               state_d = unpack_pkg::ST_LAST;
            end
         end
         unpack_pkg::ST_LAST: begin
            if (cmd_o.take || !has_bits) begin
               state_d = unpack_pkg::ST_STREAM;
            end
         end
         default: begin
            state_d = unpack_pkg::ST_STREAM;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= unpack_pkg::ST_STREAM;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

/* source/unpack_pkg.sv */
package unpack_pkg;

   // width of the bit-level count and of the width request
   // 8 bits covers a queue of up to 255 bits, so IN_W stays at or below 127
   localparam int unsigned LEVEL_W = 8;

   // controller state
   typedef enum logic [1:0] {
      // normal streaming of words and fields
      ST_STREAM = 2'd0,
      // draining full fields after a flush request
      ST_FLUSH  = 2'd1,
      // padded final field on the output
      ST_LAST   = 2'd2
   } ctrl_state_e;

   // per-cycle command from the controller to the data blocks
   typedef struct packed {
      // append the input word at this edge
      logic load;
      // remove the presented field at this edge
      logic take;
      // presented field is the zero-padded final one
      logic pad;
   } shift_cmd_t;

endpackage

/* verif/unpack_props.sv */
`timescale 1ns/10ps

module unpack_props #(
   parameter int unsigned IN_W    = 16,
   parameter int unsigned FIELD_W = 12
) (
   input logic                           clk_i,
   input logic                           rst_n_i,
   input logic                           in_ready_o,
   input logic                           field_valid_o,
   input logic                           field_ready_i,
   input logic                           last_o,
   input logic [FIELD_W-1:0]             field_o,
   input logic [unpack_pkg::LEVEL_W-1:0] level_i,
   input unpack_pkg::ctrl_state_e        state_i
);

   // a stalled field holds its value and last flag
   property field_held;
      @(posedge clk_i) disable iff (!rst_n_i)
         (field_valid_o && !field_ready_i) |=> ($stable(field_o) && $stable(last_o));
   endproperty

   property level_bounded;
      @(posedge clk_i) disable iff (!rst_n_i)
         level_i <= 2 * IN_W;
   endproperty

   // no words accepted while flushing
   property ready_only_streaming;
      @(posedge clk_i) disable iff (!rst_n_i)
         (state_i != unpack_pkg::ST_STREAM) |-> !in_ready_o;
   endproperty

   assert property (field_held)
      else $error("field_o or last_o changed while the field was stalled");
   assert property (level_bounded)
      else $error("bit level went above twice the word width");
   assert property (ready_only_streaming)
      else $error("in_ready_o was high outside streaming");

endmodule

bind bit_unpacker unpack_props #(
   .IN_W   (IN_W),
   .FIELD_W(FIELD_W)
) u_props (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .in_ready_o   (in_ready_o),
   .field_valid_o(field_valid_o),
   .field_ready_i(field_ready_i),
   .last_o       (last_o),
   .field_o      (field_o),
   .level_i      (level),
   .state_i      (u_ctrl.state_q)
);

/* verif/unpack_tb.sv */
`timescale 1ns/10ps

module unpack_tb;

   localparam int unsigned IN_W      = 16;
   localparam int unsigned FIELD_W   = 12;
   localparam int unsigned NUM_WORDS = 400;
   localparam time         CLK_PERIOD = 100ns;
   // at most 40 cycles per word under back-pressure, plus reset and final drain
   localparam int unsigned WATCHDOG_CYCLES = NUM_WORDS * 40 + 500;

   // model view of the flush sequence
   localparam int MODE_STREAM = 0;
   localparam int MODE_FLUSH  = 1;
   localparam int MODE_LAST   = 2;

   logic                           clk_i;
   logic                           rst_n_i;
   logic                           in_valid_i;
   logic [IN_W-1:0]                in_data_i;
   logic                           in_ready_o;
   logic                           flush_i;
   logic [unpack_pkg::LEVEL_W-1:0] width_i;
   logic                           field_valid_o;
   logic [FIELD_W-1:0]             field_o;
   logic                           last_o;
   logic                           field_ready_i;

   // bit queue of the pushed stream, oldest bit at index 0
   bit   model_q[$];
   int   model_mode;
   int   seed;
   int   words_sent;
   int   last_fields;
   logic took_last;
   logic loaded_last;

   bit_unpacker #(
      .IN_W   (IN_W),
      .FIELD_W(FIELD_W)
   ) DUT (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .in_data_i    (in_data_i),
      .in_ready_o   (in_ready_o),
      .flush_i      (flush_i),
      .width_i      (width_i),
      .field_valid_o(field_valid_o),
      .field_o      (field_o),
      .last_o       (last_o),
      .field_ready_i(field_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   task automatic stop_on_failure();
      $display("sim failed");
      $fatal(1, "unpack_tb stopped at the first failure");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, name, got, exp);
      stop_on_failure();
   endtask

   // n head bits of the model, MSB-first, shifted up to fill w bits
   function automatic logic [FIELD_W-1:0] head_bits(input int n, input int w);
      logic [FIELD_W-1:0] f;
      int                 i;
      f = '0;
      for (i = 0; i < n; i++) begin
         f = {f[FIELD_W-2:0], model_q[i]};
      end
      return f << (w - n);
   endfunction

   task automatic drive_inputs(input logic allow_words, input logic allow_flush,
                               input logic force_flush);
      logic hold_word;
      int   r_valid;
      int   r_ready;
      int   r_width;
      int   r_flush;
      r_valid = {$random(seed)} % 4;
      r_ready = {$random(seed)} % 5;
      r_width = {$random(seed)} % FIELD_W;
      r_flush = {$random(seed)} % 60;
      // a word that was offered but not taken stays on the bus
      hold_word = in_valid_i && !loaded_last;
      if (!hold_word) begin
         in_valid_i = allow_words && (r_valid != 0);
         in_data_i  = $random(seed);
      end
      field_ready_i = (r_ready < 3);
      // width moves only after a transfer or while no field is offered
      if (took_last || !field_valid_o) begin
         width_i = 1 + r_width;
      end
      flush_i = (model_mode == MODE_STREAM) && (force_flush || (allow_flush && r_flush == 0));
   endtask

   // compare outputs just before the edge, then apply that edge's transfers
   task automatic check_and_update();
      logic               exp_ready;
      logic               exp_valid;
      logic               exp_last;
      logic               load;
      logic               take;
      logic [FIELD_W-1:0] exp_field;
      int                 w;
      int                 n;
      int                 i;
      int                 next_mode;
      w = width_i;
      n = model_q.size();
      exp_ready = (model_mode == MODE_STREAM) && (n <= IN_W);
      exp_last  = (model_mode == MODE_LAST) && (n > 0);
      exp_valid = (n >= w) || exp_last;

      assert (in_ready_o === exp_ready)
         else report_mismatch("in_ready_o", in_ready_o, exp_ready);
      assert (field_valid_o === exp_valid)
         else report_mismatch("field_valid_o", field_valid_o, exp_valid);
      assert (last_o === exp_last)
         else report_mismatch("last_o", last_o, exp_last);
      if (exp_valid) begin
         if (exp_last) begin
            exp_field = head_bits(n, w);
         end else begin
            exp_field = head_bits(w, w);
         end
         assert (field_o === exp_field)
            else report_mismatch("field_o", field_o, exp_field);
      end

      load = in_valid_i && exp_ready;
      take = exp_valid && field_ready_i;

      next_mode = model_mode;
      case (model_mode)
         MODE_STREAM: begin
            if (flush_i) begin
               next_mode = MODE_FLUSH;
            end
         end
         MODE_FLUSH: begin
            if (n == 0) begin
               next_mode = MODE_STREAM;
            end else if (n < w) begin
               next_mode = MODE_LAST;
            end
         end
         default: begin
            if (take || n == 0) begin
               next_mode = MODE_STREAM;
            end
         end
      endcase

      // head bits leave first, a new word joins at the tail
      if (take) begin
         if (exp_last) begin
            last_fields++;
            model_q.delete();
         end else begin
            for (i = 0; i < w; i++) begin
               void'(model_q.pop_front());
            end
         end
      end
      if (load) begin
         for (i = IN_W - 1; i >= 0; i--) begin
            model_q.push_back(in_data_i[i]);
         end
         words_sent++;
      end
      model_mode  = next_mode;
      took_last   = take;
      loaded_last = load;
   endtask

   task automatic run_cycle(input logic allow_words, input logic allow_flush,
                            input logic force_flush);
      @(negedge clk_i);
      drive_inputs(allow_words, allow_flush, force_flush);
      #(CLK_PERIOD / 2 - 1ns);
      check_and_update();
   endtask

   initial begin
      seed          = 32'h7a65;
      rst_n_i       = 1'b0;
      in_valid_i    = 1'b0;
      in_data_i     = '0;
      flush_i       = 1'b0;
      width_i       = 8'd1;
      field_ready_i = 1'b0;
      model_mode    = MODE_STREAM;
      words_sent    = 0;
      last_fields   = 0;
      took_last     = 1'b0;
      loaded_last   = 1'b0;

      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;
      #(CLK_PERIOD / 2 - 1ns);
      assert (in_ready_o === 1'b1)
         else report_mismatch("in_ready_o", in_ready_o, 1'b1);
      assert (field_valid_o === 1'b0)
         else report_mismatch("field_valid_o", field_valid_o, 1'b0);
      assert (last_o === 1'b0)
         else report_mismatch("last_o", last_o, 1'b0);
      check_and_update();

      // random stream with random flushes
      while (words_sent < NUM_WORDS) begin
         run_cycle(1'b1, 1'b1, 1'b0);
      end

      // let a held word land and any running flush end
      while (in_valid_i || model_mode != MODE_STREAM) begin
         run_cycle(1'b0, 1'b0, 1'b0);
      end
      run_cycle(1'b0, 1'b0, 1'b1);
      while (model_mode != MODE_STREAM || model_q.size() != 0) begin
         run_cycle(1'b0, 1'b0, 1'b0);
      end

      // empty queue in the model, so the DUT must offer nothing more
      run_cycle(1'b0, 1'b0, 1'b0);

      if (last_fields == 0) begin
         $display("[ERROR] %0t: no padded last field was ever transferred", $time);
         stop_on_failure();
      end else begin
         $display("sim passed");
         $finish;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("[ERROR] %0t: watchdog expired before the run completed", $time);
      stop_on_failure();
   end

endmodule

/* vlog.f */
source/unpack_pkg.sv
source/unpack_ctrl.sv
source/bit_level_cnt.sv
source/bit_shift_reg.sv
source/bit_unpacker.sv
verif/unpack_props.sv
verif/unpack_tb.sv
